// File: compile.f
+incdir+.
tensor_data_pkg.sv
tensor_ctrl_pkg.sv
tensor_index_counter.sv
tensor_transpose_fsm.sv
tensor_buffer.sv
tensor_transpose.sv
tensor_transpose_asserts.sv
tensor_transpose_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tensor transpose testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal -f compile.f \
  --top-module tensor_transpose_tb -o tensor_transpose_sim

status=0
./obj_dir/tensor_transpose_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"

// File: tensor_transpose_tb.sv
// Directed runs on one DUT; the model assumes every axis size is 1 to 8 and one run at a time
`timescale 1ns/10ps
`default_nettype none

`include "tensor_config.svh"

module tensor_transpose_tb;

  localparam int RANDOM_RUNS = 6;

  logic                          CLK;
  logic                          RST;
  logic                          start;
  tensor_data_pkg::shape_t       shape_in;
  logic                          data_in_valid;
  tensor_data_pkg::data_t        data_in;
  wire logic                     ready;
  wire tensor_ctrl_pkg::enable_t out_enable;
  wire tensor_data_pkg::data_t   data_out;

  int checks = 0;
  int errors = 0;
  int cycles = 0;
  int cycle_limit = 0;

  // Tensor A stored linearly in i-j-k order
  tensor_data_pkg::data_t a_mem [`TT_DEPTH];

  tensor_transpose uut (
    .CLK(CLK), .RST(RST), .start(start), .shape_in(shape_in),
    .data_in_valid(data_in_valid), .data_in(data_in), .ready(ready),
    .out_enable(out_enable), .data_out(data_out)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: simulation ran past %0d cycles", cycle_limit);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Budget covers load with gaps plus latency, drain and done
  function automatic int cycle_budget(input int n);
    return 4 * n + 16;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic drive_shape_random();
    shape_in.size_i = tensor_data_pkg::dim_t'(1 + $urandom_range(7));
    shape_in.size_j = tensor_data_pkg::dim_t'(1 + $urandom_range(7));
    shape_in.size_k = tensor_data_pkg::dim_t'(1 + $urandom_range(7));
  endtask

  ////////////////////////////////////////
  // One complete run against the model
  ////////////////////////////////////////

  task automatic run_transpose(input int si, input int sj, input int sk, input int gap_pct,
                               input bit seq_data, input bit poke_start);
    int n;
    int e;
    int p;
    int lat;
    int jj;
    int ii;
    int kk;
    tensor_ctrl_pkg::enable_t exp_en;
    n = si * sj * sk;
    for (e = 0; e < n; e++) begin
      a_mem[e] = seq_data ? tensor_data_pkg::data_t'(e) : tensor_data_pkg::data_t'($urandom);
    end
    shape_in.size_i = tensor_data_pkg::dim_t'(si);
    shape_in.size_j = tensor_data_pkg::dim_t'(sj);
    shape_in.size_k = tensor_data_pkg::dim_t'(sk);
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    drive_shape_random();
    check_value("ready", 32'(ready), 32'h0);
    // Load A with optional idle cycles between strobes
    for (e = 0; e < n; e++) begin
      start = 1'b0;
      while ($urandom_range(99) < gap_pct) begin
        data_in_valid = 1'b0;
        data_in = tensor_data_pkg::data_t'($urandom);
        @(negedge CLK);
      end
      data_in_valid = 1'b1;
      data_in = a_mem[e];
      start = poke_start && (e == n / 2);
      @(negedge CLK);
    end
    start = 1'b0;
    data_in_valid = 1'b0;
    // First element expected two cycles after the last accepted input
    lat = 1;
    while (!out_enable.k && lat < 8) begin
      @(negedge CLK);
      lat++;
    end
    checks++;
    assert (lat == 2) else begin
      $display("First output came %0d cycles after the last accepted input instead of 2 at %0t",
               lat, $time);
      errors++;
    end
    // B[j][i][k] = A[i][j][k] streamed with j outermost
    p = 0;
    for (jj = 0; jj < sj; jj++) begin
      for (ii = 0; ii < si; ii++) begin
        for (kk = 0; kk < sk; kk++) begin
          exp_en.k = 1'b1;
          exp_en.i = (kk == 0);
          exp_en.j = (ii == 0) && (kk == 0);
          check_value("data_out", 32'(data_out), 32'(a_mem[(ii * sj + jj) * sk + kk]));
          check_value("out_enable", 32'(out_enable), 32'(exp_en));
          check_value("ready", 32'(ready), 32'h0);
          start = poke_start && (p == n / 2);
          data_in_valid = poke_start ? 1'($urandom) : 1'b0;
          p++;
          @(negedge CLK);
        end
      end
    end
    start = 1'b0;
    data_in_valid = 1'b0;
    // Cycle right after the last element
    check_value("ready", 32'(ready), 32'h1);
    check_value("out_enable", 32'(out_enable), 32'h0);
    check_value("data_out", 32'(data_out), 32'h0);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic idle_after_reset();
    int c;
    for (c = 0; c < 10; c++) begin
      check_value("ready", 32'(ready), 32'h0);
      check_value("out_enable", 32'(out_enable), 32'h0);
      check_value("data_out", 32'(data_out), 32'h0);
      // Strobes in idle must be dropped
      data_in_valid = 1'($urandom);
      data_in = tensor_data_pkg::data_t'($urandom);
      @(negedge CLK);
    end
    data_in_valid = 1'b0;
  endtask

  task automatic small_sequential_run();
    run_transpose(2, 3, 4, 0, 1'b1, 1'b0);
  endtask

  task automatic random_shape_runs();
    int r;
    int si;
    int sj;
    int sk;
    for (r = 0; r < RANDOM_RUNS; r++) begin
      si = 1 + $urandom_range(7);
      sj = 1 + $urandom_range(7);
      sk = 1 + $urandom_range(7);
      run_transpose(si, sj, sk, 40, 1'b0, 1'b0);
    end
  endtask

  task automatic edge_shape_runs();
    run_transpose(1, 1, 1, 0, 1'b0, 1'b0);
    run_transpose(8, 8, 8, 20, 1'b0, 1'b0);
    run_transpose(1, 8, 1, 0, 1'b0, 1'b0);
  endtask

  task automatic stray_start_and_restart();
    // Stray starts in load and drain followed by a new shape right after ready
    run_transpose(4, 5, 3, 25, 1'b0, 1'b1);
    run_transpose(3, 2, 7, 0, 1'b0, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h41c2_91d3));
    cycle_limit = 40 + cycle_budget(24) + RANDOM_RUNS * cycle_budget(512) + cycle_budget(1)
                  + cycle_budget(512) + cycle_budget(8) + cycle_budget(60) + cycle_budget(42);
    RST = 1'b1;
    start = 1'b0;
    shape_in = '0;
    data_in_valid = 1'b0;
    data_in = '0;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    idle_after_reset();
    small_sequential_run();
    random_shape_runs();
    edge_shape_runs();
    stray_start_and_restart();
    @(negedge CLK);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tensor_transpose_asserts.sv
// Protocol checks bound into tensor_transpose; the state probe reaches an internal wire
`timescale 1ns/10ps
`default_nettype none

module tensor_transpose_asserts (
  input wire logic                        CLK,
  input wire logic                        RST,
  input wire logic                        ready,
  input wire tensor_ctrl_pkg::enable_t    out_enable,
  input wire tensor_data_pkg::data_t      data_out,
  input wire tensor_ctrl_pkg::fsm_state_t state
);

  ////////////////////////////////////////
  // Output stream protocol
  ////////////////////////////////////////

  // Done pulse lasts one cycle
  ready_pulse: assert property (@(posedge CLK) disable iff (RST) ready |=> !ready)
    else $error("ready stayed high for more than one cycle");

  // Row and block starts only on valid elements
  flags_need_k: assert property (@(posedge CLK) disable iff (RST)
    (out_enable.i || out_enable.j) |-> out_enable.k)
    else $error("row or block flag raised without element flag");

  // Done comes after the stream, never beside it
  ready_apart: assert property (@(posedge CLK) disable iff (RST) !(ready && out_enable.k))
    else $error("ready overlaps an output element");

  // Idle and load keep the output quiet
  quiet_outside_drain: assert property (@(posedge CLK) disable iff (RST)
    (state == tensor_ctrl_pkg::ST_IDLE || state == tensor_ctrl_pkg::ST_LOAD)
    |-> (!out_enable.k && data_out == '0))
    else $error("output active while idle or loading");

endmodule

bind tensor_transpose tensor_transpose_asserts u_asserts (
  .CLK(CLK), .RST(RST), .ready(ready), .out_enable(out_enable),
  .data_out(data_out), .state(state)
);

`default_nettype wire

// File: tensor_transpose.sv
// No back-pressure on the output; the sink must take one element per cycle during drain
`timescale 1ns/10ps
`default_nettype none

module tensor_transpose (
  input  wire logic                     CLK,
  input  wire logic                     RST,
  input  wire logic                     start,
  input  wire tensor_data_pkg::shape_t  shape_in,
  input  wire logic                     data_in_valid,
  input  wire tensor_data_pkg::data_t   data_in,
  output wire logic                     ready,
  output wire tensor_ctrl_pkg::enable_t out_enable,
  output wire tensor_data_pkg::data_t   data_out
);

  tensor_data_pkg::shape_t          shape;
  wire tensor_ctrl_pkg::fsm_state_t state;
  wire tensor_ctrl_pkg::order_t     order;
  wire tensor_ctrl_pkg::index_t     index;
  wire logic                        clear;
  wire logic                        step;
  wire logic                        write_enable;
  wire logic                        drain_valid;
  wire logic                        wrap;

  ////////////////////////////////////////
  // Shape register
  ////////////////////////////////////////

  // Loaded on an accepted start only
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      shape <= '0;
    end else if (clear) begin
      shape <= shape_in;
    end
  end

  tensor_transpose_fsm u_fsm (
    .CLK(CLK), .RST(RST), .start(start), .data_in_valid(data_in_valid), .wrap(wrap),
    .state(state), .clear(clear), .step(step), .order(order),
    .write_enable(write_enable), .drain_valid(drain_valid), .ready(ready)
  );

  tensor_index_counter u_counter (
    .CLK(CLK), .RST(RST), .clear(clear), .step(step), .order(order),
    .shape(shape), .index(index), .wrap(wrap)
  );

  tensor_buffer u_buffer (
    .CLK(CLK), .RST(RST), .shape(shape), .index(index), .write_enable(write_enable),
    .data_in(data_in), .drain_valid(drain_valid), .data_out(data_out),
    .out_enable(out_enable)
  );

endmodule

`default_nettype wire

// File: tensor_buffer.sv
// Single tensor store of 512 entries; memory contents are undefined until loaded
`timescale 1ns/10ps
`default_nettype none

`include "tensor_config.svh"

module tensor_buffer (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire tensor_data_pkg::shape_t shape,
  input  wire tensor_ctrl_pkg::index_t index,
  input  wire logic                    write_enable,
  input  wire tensor_data_pkg::data_t  data_in,
  input  wire logic                    drain_valid,
  output tensor_data_pkg::data_t       data_out,
  output tensor_ctrl_pkg::enable_t     out_enable
);

  tensor_data_pkg::data_t mem [`TT_DEPTH];
  tensor_data_pkg::addr_t addr;

  ////////////////////////////////////////
  // Address in A layout
  ////////////////////////////////////////

  // ((i*J)+j)*K+k, drain scan order turns this into the transpose
  assign addr = ((tensor_data_pkg::addr_t'(index.i) * tensor_data_pkg::addr_t'(shape.size_j)
                 + tensor_data_pkg::addr_t'(index.j)) * tensor_data_pkg::addr_t'(shape.size_k))
                + tensor_data_pkg::addr_t'(index.k);

  // Element store
  always_ff @(posedge CLK) begin
    if (write_enable) begin
      mem[addr] <= data_in;
    end
  end

  ////////////////////////////////////////
  // Registered read and flags
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out   <= '0;
      out_enable <= '0;
    end else begin
      // Zero outside drain
      data_out     <= drain_valid ? mem[addr] : '0;
      out_enable.k <= drain_valid;
      // Row start
      out_enable.i <= drain_valid && (index.k == '0);
      // Block start
      out_enable.j <= drain_valid && (index.i == '0) && (index.k == '0);
    end
  end

endmodule

`default_nettype wire

// File: tensor_transpose_fsm.sv
// No back-pressure: every drain cycle yields one element, and start is ignored outside idle
`timescale 1ns/10ps
`default_nettype none

module tensor_transpose_fsm (
  input  wire logic                     CLK,
  input  wire logic                     RST,
  input  wire logic                     start,
  input  wire logic                     data_in_valid,
  input  wire logic                     wrap,
  output tensor_ctrl_pkg::fsm_state_t   state,
  output logic                          clear,
  output logic                          step,
  output tensor_ctrl_pkg::order_t       order,
  output logic                          write_enable,
  output logic                          drain_valid,
  output logic                          ready
);

  tensor_ctrl_pkg::fsm_state_t state_next;

  ////////////////////////////////////////
  // State register and done pulse
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= tensor_ctrl_pkg::ST_IDLE;
      ready <= 1'b0;
    end else begin
      state <= state_next;
      // One cycle after done, lines up behind the last output element
      ready <= (state == tensor_ctrl_pkg::ST_DONE);
    end
  end

  ////////////////////////////////////////
  // Transitions
  ////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      tensor_ctrl_pkg::ST_IDLE: begin
        if (start) begin
          state_next = tensor_ctrl_pkg::ST_LOAD;
        end
      end
      tensor_ctrl_pkg::ST_LOAD: begin
        // Leave on the edge that takes the last element
        if (data_in_valid && wrap) begin
          state_next = tensor_ctrl_pkg::ST_DRAIN;
        end
      end
      tensor_ctrl_pkg::ST_DRAIN: begin
        if (wrap) begin
          state_next = tensor_ctrl_pkg::ST_DONE;
        end
      end
      tensor_ctrl_pkg::ST_DONE: begin
        state_next = tensor_ctrl_pkg::ST_IDLE;
      end
      default: begin
        state_next = tensor_ctrl_pkg::ST_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // Counter and buffer controls
  ////////////////////////////////////////

  // Accepted start, also loads the shape register
  assign clear        = (state == tensor_ctrl_pkg::ST_IDLE) && start;
  assign write_enable = (state == tensor_ctrl_pkg::ST_LOAD) && data_in_valid;
  assign drain_valid  = (state == tensor_ctrl_pkg::ST_DRAIN);

  // Load steps per strobe, drain steps every cycle
  assign step  = write_enable | drain_valid;
  assign order = drain_valid ? tensor_ctrl_pkg::ORDER_JIK : tensor_ctrl_pkg::ORDER_IJK;

endmodule

`default_nettype wire

// File: tensor_index_counter.sv
// Shape must hold nonzero sizes of at most 8 and stay stable for the whole scan
`timescale 1ns/10ps
`default_nettype none

module tensor_index_counter (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire logic                    clear,
  input  wire logic                    step,
  input  wire tensor_ctrl_pkg::order_t order,
  input  wire tensor_data_pkg::shape_t shape,
  output tensor_ctrl_pkg::index_t      index,
  output logic                         wrap
);

  ////////////////////////////////////////
  // Last-position detection
  ////////////////////////////////////////

  tensor_ctrl_pkg::index_t index_next;
  logic last_i;
  logic last_j;
  logic last_k;

  assign last_i = (tensor_data_pkg::dim_t'(index.i) == shape.size_i - 1'b1);
  assign last_j = (tensor_data_pkg::dim_t'(index.j) == shape.size_j - 1'b1);
  assign last_k = (tensor_data_pkg::dim_t'(index.k) == shape.size_k - 1'b1);

  // Final position is the same in both scan orders
  assign wrap = last_i & last_j & last_k;

  ////////////////////////////////////////
  // Next index
  ////////////////////////////////////////

  always_comb begin
    index_next = index;
    if (!last_k) begin
      index_next.k = index.k + 1'b1;
    end else begin
      // k rolls over, carry into the middle axis
      index_next.k = '0;
      if (order == tensor_ctrl_pkg::ORDER_IJK) begin
        if (!last_j) begin
          index_next.j = index.j + 1'b1;
        end else begin
          index_next.j = '0;
          index_next.i = last_i ? '0 : index.i + 1'b1;
        end
      end else begin
        // Drain order, i is the middle axis
        if (!last_i) begin
          index_next.i = index.i + 1'b1;
        end else begin
          index_next.i = '0;
          index_next.j = last_j ? '0 : index.j + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index <= '0;
    end else if (clear) begin
      index <= '0;
    end else if (step) begin
      index <= index_next;
    end
  end

endmodule

`default_nettype wire

// File: tensor_ctrl_pkg.sv
// Index width comes from tensor_config.svh, which must be on the include path
`default_nettype none

`include "tensor_config.svh"

package tensor_ctrl_pkg;

  typedef logic [`TT_IDX_W-1:0] idx_t;

  typedef struct packed {
    idx_t i;
    idx_t j;
    idx_t k;
  } index_t;

  // Load scans i outermost, drain scans j outermost
  typedef enum logic {ORDER_IJK, ORDER_JIK} order_t;

  typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_DRAIN, ST_DONE} fsm_state_t;

  // Output stream flags
  typedef struct packed {
    logic i;
    logic j;
    logic k;
  } enable_t;

endpackage

`default_nettype wire

// File: tensor_data_pkg.sv
// Widths come from tensor_config.svh, which must be on the include path
`default_nettype none

`include "tensor_config.svh"

package tensor_data_pkg;

  // One tensor element
  typedef logic [`TT_DATA_W-1:0] data_t;

  // Size of one axis, 1 to 8
  typedef logic [`TT_DIM_W-1:0] dim_t;

  // Linear address into the element buffer
  typedef logic [`TT_ADDR_W-1:0] addr_t;

  // Tensor shape as sampled on start
  typedef struct packed {
    dim_t size_i;
    dim_t size_j;
    dim_t size_k;
  } shape_t;

endpackage

`default_nettype wire

// File: tensor_config.svh
// Axis sizes run from 1 to 8 and the buffer holds one tensor of at most 512 elements
`ifndef TENSOR_CONFIG_SVH
`define TENSOR_CONFIG_SVH

// Element width
`define TT_DATA_W   16

// Axis size field, holds 1 to 8
`define TT_DIM_W    4

// Axis index, holds 0 to 7
`define TT_IDX_W    3
`define TT_MAX_DIM  8

// Linear buffer, 8 * 8 * 8 entries
`define TT_ADDR_W   9
`define TT_DEPTH    512

`endif
